// File: src/mfp_defines.svh
`ifndef MFP_DEFINES_SVH
`define MFP_DEFINES_SVH

// byte address of register word 0, aligned to the 8-word window.
`define MFP_GPIO_BASE        32'h1f80_0000

// consecutive stable synchronized cycles before a debounced bit moves.
`define MFP_DEBOUNCE_CYCLES  16

// cpu_step period in clock cycles for the medium and slow modes.
`define MFP_DIV_MID          4
`define MFP_DIV_LO           16

// cycles each display digit stays lit.
`define MFP_SCAN_CYCLES      8

`endif

// File: src/mfp_pkg.sv
package mfp_pkg;

    // processor step rate, chosen by the two lowest debounced switches.
    typedef enum logic [1:0] {
        CLK_FULL = 2'd0,  // step on every cycle.
        CLK_MID  = 2'd1,
        CLK_LO   = 2'd2
    } mfp_clk_mode_t;

    // word index inside the register window.
    typedef enum logic [2:0] {
        REG_SWITCHES   = 3'd0,  // read only.
        REG_BUTTONS    = 3'd1,  // read only.
        REG_RED_LEDS   = 3'd2,
        REG_GREEN_LEDS = 3'd3,
        REG_SEG_VALUE  = 3'd4,
        REG_SEG_ENABLE = 3'd5
    } mfp_gpio_reg_t;

endpackage

// File: src/mfp_switch_debouncer.sv
`include "mfp_defines.svh"

module mfp_switch_debouncer #(
    parameter int width = 1
) (
    input  logic             clk,
    input  logic             reset,
    input  logic [width-1:0] sw_in,
    output logic [width-1:0] sw_out
);

    localparam int cnt_w = $clog2(`MFP_DEBOUNCE_CYCLES + 1);
    localparam logic [cnt_w-1:0] cnt_last = cnt_w'(`MFP_DEBOUNCE_CYCLES - 1);

    logic [width-1:0] sync_meta;  // first stage, may go metastable.
    logic [width-1:0] sync_q;
    logic [cnt_w-1:0] stable_cnt [width];

    always_ff @(posedge clk) begin
        if (reset) begin
            sync_meta <= '0;
            sync_q    <= '0;
        end else begin
            sync_meta <= sw_in;
            sync_q    <= sync_meta;
        end
    end

    // a single bit that differs from sw_out and then toggles becomes equal
    // to sw_out again, so the equality test also restarts on a change.
    for (genvar i = 0; i < width; i++) begin : g_bit
        always_ff @(posedge clk) begin
            if (reset) begin
                stable_cnt[i] <= '0;
                sw_out[i]     <= 1'b0;
            end else if (sync_q[i] == sw_out[i]) begin
                stable_cnt[i] <= '0;
            end else if (stable_cnt[i] == cnt_last) begin
                stable_cnt[i] <= '0;
                sw_out[i]     <= sync_q[i];  // held long enough.
            end else begin
                stable_cnt[i] <= stable_cnt[i] + 1'b1;
            end
        end
    end

endmodule

// File: src/mfp_clock_enable_divider.sv
`include "mfp_defines.svh"

module mfp_clock_enable_divider (
    input  logic                  clk,
    input  logic                  reset,
    input  mfp_pkg::mfp_clk_mode_t mode,
    output logic                  cpu_step
);

    import mfp_pkg::*;

    localparam int cnt_w = $clog2(`MFP_DIV_LO);

    mfp_clk_mode_t    mode_q;
    logic [cnt_w-1:0] cnt;

    // reload value for a period of the mode's ratio.
    function automatic logic [cnt_w-1:0] reload_of(mfp_clk_mode_t m);
        logic [cnt_w-1:0] r;
        case (m)
            CLK_MID: r = cnt_w'(`MFP_DIV_MID - 1);
            CLK_LO:  r = cnt_w'(`MFP_DIV_LO - 1);
            default: r = '0;
        endcase
        return r;
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            mode_q   <= CLK_FULL;
            cnt      <= '0;
            cpu_step <= 1'b0;
        end else begin
            mode_q <= mode;
            if (mode != mode_q) begin
                cnt      <= reload_of(mode);  // restart on mode change.
                cpu_step <= 1'b0;
            end else if (mode == CLK_FULL) begin
                cnt      <= '0;
                cpu_step <= 1'b1;
            end else if (cnt == '0) begin
                cnt      <= reload_of(mode);
                cpu_step <= 1'b1;
            end else begin
                cnt      <= cnt - 1'b1;
                cpu_step <= 1'b0;
            end
        end
    end

endmodule

// File: src/mfp_gpio_regs.sv
`include "mfp_defines.svh"

module mfp_gpio_regs (
    input  logic        clk,
    input  logic        reset,

    input  logic [31:0] haddr,
    input  logic [31:0] hwdata,
    input  logic        hwrite,
    output logic [31:0] hrdata,

    input  logic [15:0] switches,
    input  logic [ 4:0] buttons,

    output logic [15:0] red_leds,
    output logic [ 8:0] green_leds,
    output logic [31:0] seg_value,
    output logic [ 7:0] seg_enable
);

    import mfp_pkg::*;

    localparam logic [31:0] gpio_base = `MFP_GPIO_BASE;

    logic          in_window;
    mfp_gpio_reg_t reg_idx;
    logic [31:0]   rdata_next;

    // 8-word window; the low two address bits select a byte and are ignored.
    assign in_window = (haddr[31:5] == gpio_base[31:5]);
    assign reg_idx   = mfp_gpio_reg_t'(haddr[4:2]);

    always_ff @(posedge clk) begin
        if (reset) begin
            red_leds   <= '0;
            green_leds <= '0;
            seg_value  <= '0;
            seg_enable <= '0;
        end else if (hwrite && in_window) begin
            case (reg_idx)
                REG_RED_LEDS:   red_leds   <= hwdata[15:0];
                REG_GREEN_LEDS: green_leds <= hwdata[8:0];
                REG_SEG_VALUE:  seg_value  <= hwdata;
                REG_SEG_ENABLE: seg_enable <= hwdata[7:0];
                default: ;  // switches, buttons and holes are read only.
            endcase
        end
    end

    always_comb begin
        rdata_next = '0;
        if (in_window) begin
            case (reg_idx)
                REG_SWITCHES:   rdata_next = {16'b0, switches};
                REG_BUTTONS:    rdata_next = {27'b0, buttons};
                REG_RED_LEDS:   rdata_next = {16'b0, red_leds};
                REG_GREEN_LEDS: rdata_next = {23'b0, green_leds};
                REG_SEG_VALUE:  rdata_next = seg_value;
                REG_SEG_ENABLE: rdata_next = {24'b0, seg_enable};
                default:        rdata_next = '0;
            endcase
        end
    end

    // read data lands one cycle after the address and holds over writes.
    always_ff @(posedge clk) begin
        if (reset) begin
            hrdata <= '0;
        end else if (!hwrite) begin
            hrdata <= rdata_next;
        end
    end

endmodule

// File: src/mfp_seven_segment_scan.sv
`include "mfp_defines.svh"

module mfp_seven_segment_scan (
    input  logic        clk,
    input  logic        reset,
    input  logic [31:0] seg_value,
    input  logic [ 7:0] seg_enable,
    output logic [ 7:0] an,
    output logic [ 7:0] seg
);

    localparam int scan_w = $clog2(`MFP_SCAN_CYCLES);
    localparam logic [scan_w-1:0] scan_last = scan_w'(`MFP_SCAN_CYCLES - 1);

    logic [scan_w-1:0] scan_cnt;
    logic [2:0]        digit;
    logic [3:0]        nibble;
    logic [6:0]        segs_on;  // a..g, active high.

    always_ff @(posedge clk) begin
        if (reset) begin
            scan_cnt <= '0;
            digit    <= '0;
        end else if (scan_cnt == scan_last) begin
            scan_cnt <= '0;
            digit    <= digit + 1'b1;  // wraps after digit 7.
        end else begin
            scan_cnt <= scan_cnt + 1'b1;
        end
    end

    assign nibble = seg_value[digit*4 +: 4];

    always_comb begin
        case (nibble)
            4'h0: segs_on = 7'b1111110;
            4'h1: segs_on = 7'b0110000;
            4'h2: segs_on = 7'b1101101;
            4'h3: segs_on = 7'b1111001;
            4'h4: segs_on = 7'b0110011;
            4'h5: segs_on = 7'b1011011;
            4'h6: segs_on = 7'b1011111;
            4'h7: segs_on = 7'b1110000;
            4'h8: segs_on = 7'b1111111;
            4'h9: segs_on = 7'b1111011;
            4'ha: segs_on = 7'b1110111;
            4'hb: segs_on = 7'b0011111;
            4'hc: segs_on = 7'b1001110;
            4'hd: segs_on = 7'b0111101;
            4'he: segs_on = 7'b1001111;
            default: segs_on = 7'b1000111;
        endcase
    end

    // seg is {a, b, c, d, e, f, g, dp}, all active low.
    always_comb begin
        if (seg_enable[digit]) begin
            an  = ~(8'b1 << digit);
            seg = {~segs_on, 1'b1};  // dp stays dark.
        end else begin
            an  = 8'hff;
            seg = 8'hff;
        end
    end

endmodule

// File: src/nexys4_ddr_io.sv
module nexys4_ddr_io (
    input  logic        clk,
    input  logic        reset,

    input  logic        btnc,
    input  logic        btnu,
    input  logic        btnl,
    input  logic        btnr,
    input  logic        btnd,

    input  logic [15:0] sw,

    output logic [15:0] led,

    output logic        led16_b,
    output logic        led16_g,
    output logic        led16_r,
    output logic        led17_b,
    output logic        led17_g,
    output logic        led17_r,

    output logic        ca,
    output logic        cb,
    output logic        cc,
    output logic        cd,
    output logic        ce,
    output logic        cf,
    output logic        cg,
    output logic        dp,

    output logic [ 7:0] an,

    input  logic [31:0] haddr,
    input  logic [31:0] hwdata,
    input  logic        hwrite,
    output logic [31:0] hrdata,

    output logic        cpu_step
);

    import mfp_pkg::*;

    logic [15:0]   sw_db;
    logic [ 4:0]   btn_db;
    mfp_clk_mode_t mode;
    logic [ 8:0]   green_leds;
    logic [31:0]   seg_value;
    logic [ 7:0]   seg_enable;
    logic [ 7:0]   seg;

    mfp_switch_debouncer #(.width (16)) sw_debouncer (
        .clk    ( clk    ),
        .reset  ( reset  ),
        .sw_in  ( sw     ),
        .sw_out ( sw_db  )
    );

    mfp_switch_debouncer #(.width (5)) btn_debouncer (
        .clk    ( clk                              ),
        .reset  ( reset                            ),
        .sw_in  ( {btnu, btnd, btnl, btnc, btnr}   ),
        .sw_out ( btn_db                           )
    );

    // slow mode wins when both low switches are up.
    always_comb begin
        if (sw_db[0])
            mode = CLK_LO;
        else if (sw_db[1])
            mode = CLK_MID;
        else
            mode = CLK_FULL;
    end

    mfp_clock_enable_divider mfp_clock_enable_divider (
        .clk      ( clk      ),
        .reset    ( reset    ),
        .mode     ( mode     ),
        .cpu_step ( cpu_step )
    );

    mfp_gpio_regs mfp_gpio_regs (
        .clk        ( clk        ),
        .reset      ( reset      ),
        .haddr      ( haddr      ),
        .hwdata     ( hwdata     ),
        .hwrite     ( hwrite     ),
        .hrdata     ( hrdata     ),
        .switches   ( sw_db      ),
        .buttons    ( btn_db     ),
        .red_leds   ( led        ),
        .green_leds ( green_leds ),
        .seg_value  ( seg_value  ),
        .seg_enable ( seg_enable )
    );

    mfp_seven_segment_scan mfp_seven_segment_scan (
        .clk        ( clk        ),
        .reset      ( reset      ),
        .seg_value  ( seg_value  ),
        .seg_enable ( seg_enable ),
        .an         ( an         ),
        .seg        ( seg        )
    );

    // upper green bits have no pin on this board.
    assign {led17_r, led17_g, led17_b, led16_r, led16_g, led16_b} = green_leds[5:0];

    assign {ca, cb, cc, cd, ce, cf, cg, dp} = seg;

endmodule

// File: sim/mfp_board_sva.sv
module mfp_board_sva (
    input logic                   clk,
    input logic                   reset,
    input logic [ 7:0]            an,
    input logic                   cpu_step,
    input logic [31:0]            hrdata,
    input logic [15:0]            led,
    input mfp_pkg::mfp_clk_mode_t mode
);

    import mfp_pkg::*;

    // at most one digit driven at a time.
    a_single_anode: assert property (
        @(posedge clk) disable iff (reset) $onehot0(~an)
    ) else $error("more than one anode low: an=%b", an);

    // full rate steps on every cycle once the mode has held for two cycles.
    a_full_rate: assert property (
        @(posedge clk) disable iff (reset)
        (mode == CLK_FULL && $past(mode) == CLK_FULL) |=> cpu_step
    ) else $error("cpu_step low while the mode stays at full rate");

    a_reset_quiet: assert property (
        @(posedge clk)
        reset |=> (cpu_step == 1'b0 && hrdata == 32'h0 && led == 16'h0 && an == 8'hff)
    ) else $error("outputs not quiet during reset");

endmodule

bind nexys4_ddr_io mfp_board_sva mfp_board_sva_inst (
    .clk      ( clk      ),
    .reset    ( reset    ),
    .an       ( an       ),
    .cpu_step ( cpu_step ),
    .hrdata   ( hrdata   ),
    .led      ( led      ),
    .mode     ( mode     )
);

// File: sim/tb_nexys4_ddr_io.sv
`include "mfp_defines.svh"

module tb_nexys4_ddr_io;

    import mfp_pkg::*;

    localparam int settle_timeout = 40;  // cycles a debounced input may take.
    localparam int step_window = 64;
    localparam logic [31:0] gpio_base = `MFP_GPIO_BASE;

    logic        clk;
    logic        reset;
    logic        btnc, btnu, btnl, btnr, btnd;
    logic [15:0] sw;
    logic [15:0] led;
    logic        led16_b, led16_g, led16_r, led17_b, led17_g, led17_r;
    logic        ca, cb, cc, cd, ce, cf, cg, dp;
    logic [ 7:0] an;
    logic [31:0] haddr;
    logic [31:0] hwdata;
    logic        hwrite;
    logic [31:0] hrdata;
    logic        cpu_step;

    integer seed;
    int     test_errors;
    int     total_errors;
    int     tests_passed;
    int     tests_failed;

    logic [15:0] model_red;
    logic [ 8:0] model_green;
    logic [31:0] model_seg_value;
    logic [ 7:0] model_seg_enable;
    logic [15:0] model_sw;
    logic [ 4:0] model_btn;
    logic [31:0] model_rdata;  // word the read register should hold.

    nexys4_ddr_io nexys4_ddr_io_inst (
        .clk(clk), .reset(reset),
        .btnc(btnc), .btnu(btnu), .btnl(btnl), .btnr(btnr), .btnd(btnd),
        .sw(sw), .led(led),
        .led16_b(led16_b), .led16_g(led16_g), .led16_r(led16_r),
        .led17_b(led17_b), .led17_g(led17_g), .led17_r(led17_r),
        .ca(ca), .cb(cb), .cc(cc), .cd(cd), .ce(ce), .cf(cf), .cg(cg), .dp(dp),
        .an(an), .haddr(haddr), .hwdata(hwdata), .hwrite(hwrite), .hrdata(hrdata),
        .cpu_step(cpu_step)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    initial begin
        #400000;
        $display("watchdog expired: the simulation did not reach its end in time");
        $display("Some tests failed");
        $finish;
    end

    // a cycle without a write loads the read register.
    task automatic next_cycle();
        if (!hwrite)
            model_rdata = expected_read(haddr);
        @(posedge clk);
        #1;
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        assert (got === expected) else begin
            $display("MISMATCH time=%0t signal=%s got=%h expected=%h",
                     $time, name, got, expected);
            test_errors++;
        end
    endtask

    task automatic finish_test(input string name);
        if (test_errors == 0) begin
            $display("test %s: PASS", name);
            tests_passed++;
        end else begin
            $display("test %s: FAIL with %0d errors", name, test_errors);
            tests_failed++;
        end
        total_errors += test_errors;
        test_errors = 0;
    endtask

    // {a, b, c, d, e, f, g} active low, dp dark.
    function automatic logic [7:0] hex_segments(input logic [3:0] nib);
        logic [6:0] low;
        case (nib)
            4'h0: low = 7'b0000001;
            4'h1: low = 7'b1001111;
            4'h2: low = 7'b0010010;
            4'h3: low = 7'b0000110;
            4'h4: low = 7'b1001100;
            4'h5: low = 7'b0100100;
            4'h6: low = 7'b0100000;
            4'h7: low = 7'b0001111;
            4'h8: low = 7'b0000000;
            4'h9: low = 7'b0000100;
            4'ha: low = 7'b0001000;
            4'hb: low = 7'b1100000;
            4'hc: low = 7'b0110001;
            4'hd: low = 7'b1000010;
            4'he: low = 7'b0110000;
            default: low = 7'b0111000;
        endcase
        return {low, 1'b1};
    endfunction

    function automatic logic [31:0] reg_addr(input mfp_gpio_reg_t idx);
        return gpio_base + {27'b0, idx, 2'b00};
    endfunction

    function automatic logic [31:0] expected_read(input logic [31:0] addr);
        logic [31:0] word;
        word = 32'h0;
        if (addr[31:5] == gpio_base[31:5]) begin
            case (addr[4:2])
                REG_SWITCHES:   word = {16'h0, model_sw};
                REG_BUTTONS:    word = {27'h0, model_btn};
                REG_RED_LEDS:   word = {16'h0, model_red};
                REG_GREEN_LEDS: word = {23'h0, model_green};
                REG_SEG_VALUE:  word = model_seg_value;
                REG_SEG_ENABLE: word = {24'h0, model_seg_enable};
                default:        word = 32'h0;
            endcase
        end
        return word;
    endfunction

    task automatic pick_address(output logic [31:0] addr);
        logic [31:0] r;
        r = $random(seed);
        if (r[3:0] < 4'd13) begin
            addr = gpio_base + {27'b0, r[6:4], 2'b00};  // includes the two holes.
        end else begin
            addr = $random(seed);
            addr[1:0] = 2'b00;
            if (addr[31:5] == gpio_base[31:5])
                addr[20] = ~addr[20];
        end
    endtask

    task automatic bus_write(input logic [31:0] addr, input logic [31:0] data);
        haddr  = addr;
        hwdata = data;
        hwrite = 1'b1;
        next_cycle();
        hwrite = 1'b0;
        check_value("hrdata", hrdata, model_rdata);
        if (addr[31:5] == gpio_base[31:5]) begin
            case (addr[4:2])
                REG_RED_LEDS:   model_red        = data[15:0];
                REG_GREEN_LEDS: model_green      = data[8:0];
                REG_SEG_VALUE:  model_seg_value  = data;
                REG_SEG_ENABLE: model_seg_enable = data[7:0];
                default: ;
            endcase
        end
    endtask

    task automatic check_read(input logic [31:0] addr);
        haddr  = addr;
        hwrite = 1'b0;
        next_cycle();
        check_value("hrdata", hrdata, expected_read(addr));
    endtask

    task automatic check_leds();
        check_value("led", 32'(led), 32'(model_red));
        check_value("rgb", 32'({led17_r, led17_g, led17_b, led16_r, led16_g, led16_b}),
                    32'(model_green[5:0]));
    endtask

    task automatic drive_pins(input logic [15:0] sw_val, input logic [4:0] btn_val);
        sw = sw_val;
        {btnu, btnd, btnl, btnc, btnr} = btn_val;
    endtask

    task automatic apply_inputs(input logic [15:0] sw_val, input logic [4:0] btn_val);
        model_sw  = sw_val;
        model_btn = btn_val;
        drive_pins(sw_val, btn_val);
    endtask

    task automatic wait_switches_settled();
        int waited;
        waited = 0;
        haddr  = reg_addr(REG_SWITCHES);
        next_cycle();
        while (hrdata[15:0] !== model_sw && waited < settle_timeout) begin
            next_cycle();
            waited++;
        end
        assert (hrdata[15:0] === model_sw) else begin
            $display("timeout at %0t: switch register did not reach %h in %0d cycles",
                     $time, model_sw, settle_timeout);
            test_errors++;
        end
    endtask

    task automatic test_reset_state();
        check_value("hrdata", hrdata, 32'h0);
        check_leds();
        check_value("cpu_step", 32'(cpu_step), 32'h0);
        check_value("an", 32'(an), 32'hff);
        check_value("seg", 32'({ca, cb, cc, cd, ce, cf, cg, dp}), 32'hff);
        finish_test("reset_state");
    endtask

    task automatic test_bus_registers();
        logic [31:0] r;
        logic [31:0] addr;
        logic [31:0] data;
        for (int idx = 0; idx < 8; idx++) begin
            addr = gpio_base + 32'(idx * 4);
            data = $random(seed);
            bus_write(addr, data);
            check_leds();
            check_read(addr);
        end
        for (int i = 0; i < 300; i++) begin
            pick_address(addr);
            r = $random(seed);
            if (r[0]) begin
                data = $random(seed);
                bus_write(addr, data);
                check_leds();
            end else begin
                check_read(addr);
            end
        end
        finish_test("bus_registers");
    endtask

    task automatic test_debounce();
        logic [31:0] r;
        logic [15:0] sw_mask;
        logic [ 4:0] btn_mask;
        int          dur;
        for (int p = 0; p < 8; p++) begin
            r = $random(seed);
            apply_inputs(r[15:0], r[20:16]);
            repeat (40) next_cycle();
            check_read(reg_addr(REG_SWITCHES));
            check_read(reg_addr(REG_BUTTONS));
            r = $random(seed);
            sw_mask  = (r[15:0] == 16'h0) ? 16'h0001 : r[15:0];
            btn_mask = (r[20:16] == 5'h0) ? 5'h01 : r[20:16];
            dur      = (r[23:21] == 3'd0) ? 7 : int'(r[23:21]);  // 1 to 7 cycles.
            drive_pins(model_sw ^ sw_mask, model_btn ^ btn_mask);
            repeat (dur) next_cycle();
            drive_pins(model_sw, model_btn);
            for (int k = 0; k < 30; k++)
                check_read(k[0] ? reg_addr(REG_BUTTONS) : reg_addr(REG_SWITCHES));
        end
        finish_test("debounce");
    endtask

    task automatic run_step_case(input string name, input logic [1:0] low_sw,
                                 input int expected);
        logic [31:0] r;
        int          pulses;
        r = $random(seed);
        apply_inputs({r[15:2], low_sw}, model_btn);
        wait_switches_settled();
        repeat (2) next_cycle();
        pulses = 0;
        for (int c = 0; c < step_window; c++) begin
            next_cycle();
            if (cpu_step)
                pulses++;
        end
        check_value(name, 32'(pulses), 32'(expected));
    endtask

    task automatic run_display_case(input logic [31:0] value, input logic [7:0] enable);
        logic [7:0] seen;
        logic [7:0] seg_pins;
        int         low_count;
        int         active;
        bus_write(reg_addr(REG_SEG_VALUE), value);
        bus_write(reg_addr(REG_SEG_ENABLE), 32'(enable));
        seen = 8'h0;
        for (int c = 0; c < 64 * `MFP_SCAN_CYCLES; c++) begin
            low_count = 0;
            active    = 0;
            for (int d = 0; d < 8; d++) begin
                if (!an[d[2:0]]) begin
                    low_count++;
                    active = d;
                end
            end
            seg_pins = {ca, cb, cc, cd, ce, cf, cg, dp};
            if (low_count == 0) begin
                check_value("seg", 32'(seg_pins), 32'hff);
            end else begin
                check_value("an low count", 32'(low_count), 32'h1);
                assert (model_seg_enable[active[2:0]]) else begin
                    $display("display error at %0t: digit %0d is lit but not enabled",
                             $time, active);
                    test_errors++;
                end
                check_value("seg", 32'(seg_pins),
                            32'(hex_segments(4'(model_seg_value >> (4 * active)))));
                seen[active[2:0]] = 1'b1;
            end
            next_cycle();
        end
        check_value("digits seen", 32'(seen), 32'(model_seg_enable));
    endtask

    initial begin
        logic [31:0] r;
        seed = 73300;
        reset = 1'b1;
        {btnc, btnu, btnl, btnr, btnd} = 5'b0;
        sw = 16'h0;
        haddr = 32'h0;
        hwdata = 32'h0;
        hwrite = 1'b0;
        {model_red, model_green, model_seg_value, model_seg_enable} = '0;
        {model_sw, model_btn} = '0;
        model_rdata = 32'h0;
        {test_errors, total_errors, tests_passed, tests_failed} = '0;
        repeat (8) @(posedge clk);
        #1;
        test_reset_state();
        reset = 1'b0;
        test_bus_registers();
        test_debounce();
        run_step_case("cpu_step pulses mid", 2'b10, step_window / `MFP_DIV_MID);
        run_step_case("cpu_step pulses lo", 2'b01, step_window / `MFP_DIV_LO);
        run_step_case("cpu_step pulses full", 2'b00, step_window);
        run_step_case("cpu_step pulses lo+mid", 2'b11, step_window / `MFP_DIV_LO);
        finish_test("step_rate");
        r = $random(seed);
        run_display_case($random(seed), r[7:0]);
        run_display_case($random(seed), r[15:8]);
        run_display_case($random(seed), 8'hff);
        finish_test("display");
        $display("tests passed: %0d, tests failed: %0d, errors: %0d",
                 tests_passed, tests_failed, total_errors);
        if (tests_failed == 0 && total_errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// File: files.f
+incdir+src
src/mfp_pkg.sv
src/mfp_switch_debouncer.sv
src/mfp_clock_enable_divider.sv
src/mfp_gpio_regs.sv
src/mfp_seven_segment_scan.sv
src/nexys4_ddr_io.sv
sim/mfp_board_sva.sv
sim/tb_nexys4_ddr_io.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_nexys4_ddr_io
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
PASS_MSG  := All tests passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
